//--- Bender.yml
package:
  name: r5p_soc_arty

sources:
  # package first, then the leaf modules up to the board wrapper
  - source/r5p_soc_pkg.sv
  - source/r5p_reset_sync.sv
  - source/r5p_gpio_cdc.sv
  - source/r5p_bus_arbiter.sv
  - source/r5p_event_ram.sv
  - source/r5p_event_recorder.sv
  - source/r5p_event_player.sv
  - source/r5p_soc_top.sv
  - source/r5p_soc_arty.sv
  - target: test
    files:
      - verification/r5p_soc_props.sv
      - verification/r5p_soc_arty_tb.sv

//--- r5p_soc_arty.f
source/r5p_soc_pkg.sv
source/r5p_reset_sync.sv
source/r5p_gpio_cdc.sv
source/r5p_bus_arbiter.sv
source/r5p_event_ram.sv
source/r5p_event_recorder.sv
source/r5p_event_player.sv
source/r5p_soc_top.sv
source/r5p_soc_arty.sv
verification/r5p_soc_props.sv
verification/r5p_soc_arty_tb.sv

//--- source/r5p_bus_arbiter.sv
// Fixed-priority arbiter for the single event RAM port.
// The recorder writes, the player reads. Grants come in the cycle of
// the request, read data reaches the player one cycle after its grant.

`timescale 1ns/100ps

module r5p_bus_arbiter (
  input  logic                            clk,
  input  logic                            rst,
  // recorder, write only
  input  logic                            rec_req,
  input  logic [r5p_soc_pkg::RAM_AW-1:0]  rec_addr,
  input  logic [r5p_soc_pkg::REC_W-1:0]   rec_wdata,
  output logic                            rec_gnt,
  // player, read only
  input  logic                            ply_req,
  input  logic [r5p_soc_pkg::RAM_AW-1:0]  ply_addr,
  output logic                            ply_gnt,
  output logic [r5p_soc_pkg::REC_W-1:0]   ply_rdata,
  // RAM port
  output logic                            ram_en,
  output logic                            ram_we,
  output logic [r5p_soc_pkg::RAM_AW-1:0]  ram_addr,
  output logic [r5p_soc_pkg::REC_W-1:0]   ram_wdata,
  input  logic [r5p_soc_pkg::REC_W-1:0]   ram_rdata
);

//////////////////////////////////////////////////////////////////////
// grant
//////////////////////////////////////////////////////////////////////

// recorder always wins
// it never asks two cycles in a row, so the player waits one cycle at most
assign rec_gnt = rec_req;
assign ply_gnt = ply_req & ~rec_req;

//////////////////////////////////////////////////////////////////////
// RAM port mux
//////////////////////////////////////////////////////////////////////

assign ram_en    = rec_req | ply_req;
assign ram_we    = rec_req;
assign ram_addr  = rec_req ? rec_addr : ply_addr;
// only the recorder writes
assign ram_wdata = rec_wdata;

//////////////////////////////////////////////////////////////////////
// read data return
//////////////////////////////////////////////////////////////////////

// owner of the read issued last cycle
logic rd_own;

always_ff @(posedge clk) begin
  if (rst) begin
    rd_own <= 1'b0;
  end else begin
    rd_own <= ply_gnt;
  end
end

// write cycles return old RAM content, keep it away from the player
assign ply_rdata = rd_own ? ram_rdata : '0;

endmodule: r5p_bus_arbiter

//--- source/r5p_event_player.sv
// Event player.
// Reads records in ring order and replays their values with the
// recorded gaps. The first record goes out PLAY_DELAY cycles after
// its detection, two record slots hide arbitration stalls.

`timescale 1ns/100ps

module r5p_event_player (
  input  logic                            clk,
  input  logic                            rst,
  // from the recorder
  input  logic [r5p_soc_pkg::RAM_AW-1:0]  wr_ptr,
  input  logic [r5p_soc_pkg::TIME_W-1:0]  rec_time,
  // RAM read request
  output logic                            ply_req,
  output logic [r5p_soc_pkg::RAM_AW-1:0]  ply_addr,
  input  logic                            ply_gnt,
  input  logic [r5p_soc_pkg::REC_W-1:0]   ply_rdata,
  // replayed pins
  output logic [r5p_soc_pkg::IN_W-1:0]    out_val,
  output logic                            out_en
);

import r5p_soc_pkg::*;

logic [RAM_AW-1:0]    rd_ptr;
// read data arrives this cycle
logic                 rd_busy;
// nxt is the record due next, pre the one behind it
logic                 nxt_vld;
logic                 pre_vld;
logic [REC_W-1:0]     nxt_rec;
logic [REC_W-1:0]     pre_rec;
// cycles since the last presented value
logic [REC_GAP_W-1:0] since_cnt;
logic [1:0]           fill;
logic                 due;
logic                 present;
logic                 nxt_free;

//////////////////////////////////////////////////////////////////////
// fetch
//////////////////////////////////////////////////////////////////////

// slots taken or already on the way
assign fill     = 2'(nxt_vld) + 2'(pre_vld) + 2'(rd_busy);
assign ply_req  = (rd_ptr != wr_ptr) && (fill < 2'd2);
assign ply_addr = rd_ptr;

//////////////////////////////////////////////////////////////////////
// presentation
//////////////////////////////////////////////////////////////////////

// first record on the time base, the rest by gap
assign due = out_en ? (since_cnt == nxt_rec[REC_W-1:REC_VAL_W])
                    : (rec_time == TIME_W'(PLAY_DELAY - 1));
assign present  = nxt_vld && due;
assign nxt_free = present || !nxt_vld;

always_ff @(posedge clk) begin
  if (rst) begin
    rd_ptr    <= '0;
    rd_busy   <= 1'b0;
    nxt_vld   <= 1'b0;
    pre_vld   <= 1'b0;
    since_cnt <= '0;
    out_en    <= 1'b0;
  end else begin
    rd_busy <= ply_gnt;
    if (ply_gnt) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
    // slot bookkeeping, data always fills nxt first
    if (nxt_free) begin
      nxt_vld <= pre_vld | rd_busy;
      pre_vld <= pre_vld & rd_busy;
    end else if (rd_busy) begin
      pre_vld <= 1'b1;
    end
    since_cnt <= present ? REC_GAP_W'(1) : since_cnt + 1'b1;
    if (present) begin
      out_en <= 1'b1;
    end
  end
end

// record slots and output value
always_ff @(posedge clk) begin
  if (nxt_free) begin
    nxt_rec <= pre_vld ? pre_rec : ply_rdata;
  end
  if (nxt_free ? (pre_vld && rd_busy) : rd_busy) begin
    pre_rec <= ply_rdata;
  end
  if (present) begin
    out_val <= nxt_rec[REC_VAL_W-1:0];
  end
end

endmodule: r5p_event_player

//--- source/r5p_event_ram.sv
// Ring memory of event records.
// Single port, synchronous write, registered read data one cycle
// after the access. Read-first on a write cycle.

`timescale 1ns/100ps

module r5p_event_ram (
  input  logic                            clk,
  input  logic                            en,
  input  logic                            we,
  input  logic [r5p_soc_pkg::RAM_AW-1:0]  addr,
  input  logic [r5p_soc_pkg::REC_W-1:0]   wdata,
  output logic [r5p_soc_pkg::REC_W-1:0]   rdata
);

import r5p_soc_pkg::*;

// record array
logic [REC_W-1:0] mem [RAM_DEPTH];

always_ff @(posedge clk) begin
  if (en) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    // old content on a write
    rdata <= mem[addr];
  end
end

endmodule: r5p_event_ram

//--- source/r5p_event_recorder.sv
// Event recorder.
// Watches the synchronized inputs and writes one record per change,
// value plus cycles since the previous record, into the ring.

`timescale 1ns/100ps

module r5p_event_recorder (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [r5p_soc_pkg::IN_W-1:0]    in_val,
  // RAM write request
  output logic                            rec_req,
  output logic [r5p_soc_pkg::RAM_AW-1:0]  rec_addr,
  output logic [r5p_soc_pkg::REC_W-1:0]   rec_wdata,
  input  logic                            rec_gnt,
  // to the player
  output logic [r5p_soc_pkg::RAM_AW-1:0]  wr_ptr,
  output logic [r5p_soc_pkg::TIME_W-1:0]  rec_time,
  output logic                            overrun
);

import r5p_soc_pkg::*;

logic [IN_W-1:0]      last_val;
logic [REC_GAP_W-1:0] gap_cnt;
// time base runs from the first record
logic                 started;
logic                 pending;
logic                 chg;
logic                 keep;
logic                 take;

// change against the last seen value
assign chg  = (in_val != last_val);
// keepalive once the gap field is full
assign keep = started && (gap_cnt == REC_GAP_W'(GAP_MAX));
// one record slot, busy until the cycle after its grant
assign take = (chg || keep) && !pending;

always_ff @(posedge clk) begin
  if (rst) begin
    last_val <= '0;
    gap_cnt  <= '0;
    started  <= 1'b0;
    pending  <= 1'b0;
    wr_ptr   <= '0;
    rec_time <= '0;
    overrun  <= 1'b0;
  end else begin
    // rec_time reads 0 in the detection cycle of the first record
    if (started) begin
      rec_time <= rec_time + 1'b1;
    end
    // a dropped change is still consumed
    if (chg) begin
      last_val <= in_val;
    end
    gap_cnt <= take ? REC_GAP_W'(1) : gap_cnt + 1'b1;
    if (take) begin
      pending <= 1'b1;
      started <= 1'b1;
    end else if (rec_gnt) begin
      pending <= 1'b0;
    end
    if (rec_gnt) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
    // sticky until reset
    if (chg && pending) begin
      overrun <= 1'b1;
    end
  end
end

// record payload, gap high and value low
always_ff @(posedge clk) begin
  if (take) begin
    rec_wdata <= {gap_cnt, in_val};
  end
end

assign rec_req  = pending;
assign rec_addr = wr_ptr;

endmodule: r5p_event_recorder

//--- source/r5p_gpio_cdc.sv
// Input pin synchronizer.
// Plain flop array, pins arrive at sync_out CDC_SYNC_FF cycles later.

`timescale 1ns/100ps

module r5p_gpio_cdc (
  input  logic                          clk,
  input  logic [r5p_soc_pkg::IN_W-1:0]  pin_in,
  output logic [r5p_soc_pkg::IN_W-1:0]  sync_out
);

import r5p_soc_pkg::*;

// synchronizer stages, first one may go metastable
logic [IN_W-1:0] sync_ff [CDC_SYNC_FF];

always_ff @(posedge clk) begin
  sync_ff[0] <= pin_in;
  for (int i = 1; i < CDC_SYNC_FF; i++) begin
    sync_ff[i] <= sync_ff[i-1];
  end
end

// last stage is safe to use
assign sync_out = sync_ff[CDC_SYNC_FF-1];

endmodule: r5p_gpio_cdc

//--- source/r5p_reset_sync.sv
// Reset synchronizer for the board button.
// The low button sets rst at once, the release is clocked out
// through a short flop chain.

`timescale 1ns/100ps

module r5p_reset_sync (
  input  logic clk,
  input  logic arst_n,
  output logic rst
);

import r5p_soc_pkg::*;

// shift register, all ones while the button is pressed
logic [RST_SYNC_FF-1:0] rst_sr;

// async assert, zeros shift in after release
always_ff @(posedge clk or negedge arst_n) begin
  if (!arst_n) begin
    rst_sr <= '1;
  end else begin
    rst_sr <= {rst_sr[RST_SYNC_FF-2:0], 1'b0};
  end
end

// last stage is the system reset
assign rst = rst_sr[RST_SYNC_FF-1];

endmodule: r5p_reset_sync

//--- source/r5p_soc_arty.sv
// Arty board wrapper of the record-and-replay SoC.
// Synchronizes the button reset and the input pins, drives the
// replay pins as tristates and the overrun pin always.

`timescale 1ns/100ps

module r5p_soc_arty (
  input  logic                            CLK100MHZ,
  // button, active low
  input  logic                            ck_rst,
  inout  wire  [r5p_soc_pkg::PIN_W-1:0]   ck_io
);

import r5p_soc_pkg::*;

logic              clk;
logic              rst;
logic [IN_W-1:0]   pin_sync;
logic [GPIO_W-1:0] gpio_o;
logic [GPIO_W-1:0] gpio_e;
logic [GPIO_W-1:0] gpio_i;

// pin clock straight through, no PLL
assign clk = CLK100MHZ;

r5p_reset_sync rst_sync (
  .clk    (clk),
  .arst_n (ck_rst),
  .rst    (rst)
);

// only the recorded pins are sampled
r5p_gpio_cdc gpio_cdc (
  .clk      (clk),
  .pin_in   (ck_io[IN_W-1:0]),
  .sync_out (pin_sync)
);

assign gpio_i = GPIO_W'(pin_sync);

r5p_soc_top soc (
  .clk    (clk),
  .rst    (rst),
  .gpio_o (gpio_o),
  .gpio_e (gpio_e),
  .gpio_i (gpio_i)
);

// GPIO tristates
for (genvar i = 0; i < GPIO_W; i++) begin: gen_gpio
  assign ck_io[i] = gpio_e[i] ? gpio_o[i] : 1'bz;
end

// overrun flag
assign ck_io[OVR_PIN] = gpio_o[OVR_BIT];

// unused pins
for (genvar i = OVR_PIN + 1; i < PIN_W; i++) begin: gen_nc
  assign ck_io[i] = 1'bz;
end

endmodule: r5p_soc_arty

//--- source/r5p_soc_pkg.sv
// Shared constants of the GPIO record-and-replay SoC.
// Modules use the scoped names in their port lists and import
// the package in their body where they need more of it.

package r5p_soc_pkg;

  // SoC GPIO word width
  localparam int GPIO_W = 32;

  // recorded input pins
  localparam int IN_W = 16;

  // event record fields, value low and gap high
  localparam int REC_VAL_W = IN_W;
  localparam int REC_GAP_W = 16;
  localparam int REC_W     = REC_GAP_W + REC_VAL_W;

  // longest gap a record can carry, keepalive fires here
  localparam int GAP_MAX = 2**REC_GAP_W - 1;

  // ring memory of records
  localparam int RAM_AW    = 6;
  localparam int RAM_DEPTH = 2**RAM_AW;

  // replay delay from the first record detection
  localparam int PLAY_DELAY = 64;

  // recorder time base width
  localparam int TIME_W = 32;

  // pin map
  localparam int OUT_LSB = 16;
  localparam int OVR_PIN = 32;
  localparam int PIN_W   = 42;
  // overrun rides on an output bit whose pin is an input
  localparam int OVR_BIT = 0;

  // synchronizer depths
  localparam int RST_SYNC_FF = 4;
  localparam int CDC_SYNC_FF = 2;

endpackage: r5p_soc_pkg

//--- source/r5p_soc_top.sv
// SoC level of the record-and-replay core.
// Recorder and player share the event RAM through the arbiter,
// the results are packed into the GPIO words.

`timescale 1ns/100ps

module r5p_soc_top (
  input  logic                            clk,
  input  logic                            rst,
  output logic [r5p_soc_pkg::GPIO_W-1:0]  gpio_o,
  output logic [r5p_soc_pkg::GPIO_W-1:0]  gpio_e,
  input  logic [r5p_soc_pkg::GPIO_W-1:0]  gpio_i
);

import r5p_soc_pkg::*;

// recorder side
logic              rec_req;
logic              rec_gnt;
logic [RAM_AW-1:0] rec_addr;
logic [REC_W-1:0]  rec_wdata;
logic [RAM_AW-1:0] wr_ptr;
logic [TIME_W-1:0] rec_time;
logic              overrun;

// player side
logic              ply_req;
logic              ply_gnt;
logic [RAM_AW-1:0] ply_addr;
logic [REC_W-1:0]  ply_rdata;
logic [IN_W-1:0]   out_val;
logic              out_en;

// RAM port
logic              ram_en;
logic              ram_we;
logic [RAM_AW-1:0] ram_addr;
logic [REC_W-1:0]  ram_wdata;
logic [REC_W-1:0]  ram_rdata;

//////////////////////////////////////////////////////////////////////
// engines
//////////////////////////////////////////////////////////////////////

r5p_event_recorder recorder (
  .clk       (clk),
  .rst       (rst),
  .in_val    (gpio_i[IN_W-1:0]),
  .rec_req   (rec_req),
  .rec_addr  (rec_addr),
  .rec_wdata (rec_wdata),
  .rec_gnt   (rec_gnt),
  .wr_ptr    (wr_ptr),
  .rec_time  (rec_time),
  .overrun   (overrun)
);

r5p_event_player player (
  .clk       (clk),
  .rst       (rst),
  .wr_ptr    (wr_ptr),
  .rec_time  (rec_time),
  .ply_req   (ply_req),
  .ply_addr  (ply_addr),
  .ply_gnt   (ply_gnt),
  .ply_rdata (ply_rdata),
  .out_val   (out_val),
  .out_en    (out_en)
);

//////////////////////////////////////////////////////////////////////
// shared memory
//////////////////////////////////////////////////////////////////////

r5p_bus_arbiter arbiter (
  .clk       (clk),
  .rst       (rst),
  .rec_req   (rec_req),
  .rec_addr  (rec_addr),
  .rec_wdata (rec_wdata),
  .rec_gnt   (rec_gnt),
  .ply_req   (ply_req),
  .ply_addr  (ply_addr),
  .ply_gnt   (ply_gnt),
  .ply_rdata (ply_rdata),
  .ram_en    (ram_en),
  .ram_we    (ram_we),
  .ram_addr  (ram_addr),
  .ram_wdata (ram_wdata),
  .ram_rdata (ram_rdata)
);

r5p_event_ram ram (
  .clk   (clk),
  .en    (ram_en),
  .we    (ram_we),
  .addr  (ram_addr),
  .wdata (ram_wdata),
  .rdata (ram_rdata)
);

// replayed value on the upper half, overrun on a low bit
assign gpio_o = (GPIO_W'(out_val) << OUT_LSB) | (GPIO_W'(overrun) << OVR_BIT);
// low half stays input
assign gpio_e = GPIO_W'({IN_W{out_en}}) << OUT_LSB;

endmodule: r5p_soc_top

//--- verification/r5p_soc_arty_tb.sv
// Trace-driven testbench of the GPIO record-and-replay board top.
// Plays the trace file on the recorded pins and checks the replayed
// pins, the overrun pin and the unused pins on every falling edge.

`timescale 1ns/100ps

module r5p_soc_arty_tb;

import r5p_soc_pkg::*;

// DUT pins, only the recorded inputs are driven here
logic             CLK100MHZ;
logic             ck_rst;
logic [IN_W-1:0]  pin_drv;
wire  [PIN_W-1:0] ck_io;

assign ck_io[IN_W-1:0] = pin_drv;

r5p_soc_arty uut (
  .CLK100MHZ (CLK100MHZ),
  .ck_rst    (ck_rst),
  .ck_io     (ck_io)
);

// trace columns
logic [IN_W-1:0] tr_val [$];
int              tr_hold [$];
bit              tr_rnd [$];
int              tr_rep [$];
bit              tr_ovr [$];

// model, replayed values with the cycle they are due
logic [IN_W-1:0] exp_val_q [$];
int              exp_due_q [$];
logic [IN_W-1:0] exp_val;
logic [IN_W-1:0] last_drv;
bit              exp_en;
// burst drops records, values are no longer predictable
bit              lossy;
int              ovr_at;
int              cyc;
int              budget;
bit              trace_ready;
bit              checks_on;
logic [31:0]     lfsr;

initial begin
  CLK100MHZ = 1'b0;
  forever begin
    #50 CLK100MHZ = ~CLK100MHZ;
  end
end

//////////////////////////////////////////////////////////////////////
// helpers
//////////////////////////////////////////////////////////////////////

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

// one step per bit taken
task automatic draw_bits(input int n, output int bits);
  bits = 0;
  for (int b = 0; b < n; b++) begin
    bits = bits | (int'(lfsr[0]) << b);
    lfsr = lfsr_next(lfsr);
  end
endtask

task automatic stop_with_failure();
  $display("TESTBENCH FAILED");
  $fatal(1, "run stopped on the first failure");
endtask

task automatic check_value(input logic [IN_W-1:0] act, input logic [IN_W-1:0] exp,
                           input string what);
  if (act !== exp) begin
    $display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, act, exp);
    stop_with_failure();
  end
endtask

task automatic check_flag(input logic act, input logic exp, input string what);
  if (act !== exp) begin
    $display("MISMATCH at %0t: %s, got %b, expected %b", $time, what, act, exp);
    stop_with_failure();
  end
endtask

task automatic check_pins();
  // take every change that has come due
  while (exp_due_q.size() > 0 && exp_due_q[0] <= cyc) begin
    exp_val = exp_val_q.pop_front();
    void'(exp_due_q.pop_front());
    exp_en = 1'b1;
  end
  if (!lossy) begin
    if (exp_en) begin
      check_value(ck_io[OUT_LSB +: IN_W], exp_val, "replayed value");
    end else begin
      check_value(ck_io[OUT_LSB +: IN_W], {IN_W{1'bz}}, "replay pins before first record");
    end
  end
  // recorded pins carry only the bench drive
  check_value(ck_io[IN_W-1:0], pin_drv, "recorded input pins");
  check_flag(ck_io[OVR_PIN], (ovr_at >= 0) && (cyc >= ovr_at), "overrun pin");
  for (int i = OVR_PIN + 1; i < PIN_W; i++) begin
    check_flag(ck_io[i], 1'bz, "unused pin");
  end
endtask

// outputs are stable at the falling edge
task automatic step_cycle();
  @(negedge CLK100MHZ);
  cyc++;
  if (checks_on) begin
    check_pins();
  end
endtask

// called right after a falling edge
task automatic apply_input(input logic [IN_W-1:0] val, input int hold, input bit rnd,
                           input bit ovr);
  int extra;
  extra = 0;
  if (rnd) begin
    draw_bits(2, extra);
  end
  pin_drv = val;
  if (hold < 4) begin
    lossy = 1'b1;
  end
  // sync chain, detection, replay delay
  if (val != last_drv && !lossy) begin
    exp_val_q.push_back(val);
    exp_due_q.push_back(cyc + CDC_SYNC_FF + 1 + PLAY_DELAY);
  end
  last_drv = val;
  // dropped change sets the flag one cycle after detection
  if (ovr && ovr_at < 0) begin
    ovr_at = cyc + CDC_SYNC_FF + 1;
  end
  repeat (hold + extra) step_cycle();
endtask

task automatic load_trace();
  int              fd;
  int              n;
  string           line;
  logic [IN_W-1:0] val;
  int              hold;
  int              rnd;
  int              rep;
  int              ovr;
  fd = $fopen("verification/r5p_soc_trace.txt", "r");
  if (fd == 0) begin
    $display("cannot open the trace file verification/r5p_soc_trace.txt");
    stop_with_failure();
  end
  while (!$feof(fd)) begin
    n = $fgets(line, fd);
    // comment and blank lines do not scan
    if (n > 0 && $sscanf(line, "%h %d %d %d %d", val, hold, rnd, rep, ovr) == 5) begin
      tr_val.push_back(val);
      tr_hold.push_back(hold);
      tr_rnd.push_back(rnd != 0);
      tr_rep.push_back(rep);
      tr_ovr.push_back(ovr != 0);
      budget += rep * (hold + (rnd != 0 ? 3 : 0));
    end
  end
  $fclose(fd);
  if (tr_val.size() == 0) begin
    $display("the trace file holds no stimulus lines");
    stop_with_failure();
  end
endtask

//////////////////////////////////////////////////////////////////////
// stimulus and checks
//////////////////////////////////////////////////////////////////////

initial begin
  ck_rst    = 1'b0;
  pin_drv   = '0;
  last_drv  = '0;
  exp_val   = '0;
  exp_en    = 1'b0;
  lossy     = 1'b0;
  ovr_at    = -1;
  cyc       = 0;
  budget    = 0;
  checks_on = 1'b0;
  lfsr      = 32'd66622;
  load_trace();
  // reset, drain and final idle fit in the margin
  budget      = budget + PLAY_DELAY + 1000;
  trace_ready = 1'b1;
  // button held for 10 cycles
  repeat (10) step_cycle();
  ck_rst = 1'b1;
  // release through the reset chain
  repeat (RST_SYNC_FF + 2) step_cycle();
  checks_on = 1'b1;
  for (int i = 0; i < tr_val.size(); i++) begin
    for (int k = 0; k < tr_rep[i]; k++) begin
      apply_input(tr_val[i] + IN_W'(k), tr_hold[i], tr_rnd[i], tr_ovr[i]);
    end
  end
  // last replayed change
  repeat (CDC_SYNC_FF + 1 + PLAY_DELAY + 10) step_cycle();
  // final reset, flag clears and replay pins float again
  ck_rst   = 1'b0;
  pin_drv  = '0;
  last_drv = '0;
  exp_en   = 1'b0;
  lossy    = 1'b0;
  ovr_at   = -1;
  repeat (10) step_cycle();
  ck_rst = 1'b1;
  repeat (100) step_cycle();
  if (exp_due_q.size() != 0) begin
    $display("%0d expected output changes were never checked", exp_due_q.size());
    stop_with_failure();
  end else begin
    $display("TESTBENCH PASSED");
    $finish;
  end
end

// watchdog, sized from the trace
initial begin
  wait (trace_ready);
  repeat (budget) @(posedge CLK100MHZ);
  $display("timeout, the run did not finish within %0d clock cycles", budget);
  stop_with_failure();
end

endmodule: r5p_soc_arty_tb

//--- verification/r5p_soc_props.sv
// Bus and ring pointer assertions of the record-and-replay SoC.
// Bound into the arbiter, where the peer addresses are the ring
// write pointer and the player read pointer.

`timescale 1ns/100ps

module r5p_soc_props (
  input logic                            clk,
  input logic                            rst,
  input logic                            rec_req,
  input logic                            rec_gnt,
  input logic                            ply_req,
  input logic                            ply_gnt,
  input logic [r5p_soc_pkg::RAM_AW-1:0]  rec_addr,
  input logic [r5p_soc_pkg::RAM_AW-1:0]  ply_addr
);

import r5p_soc_pkg::*;

// recorder never asks in the cycle after its grant
rec_req_drops: assert property (@(posedge clk) disable iff (rst) rec_gnt |=> !rec_req)
  else $error("recorder requested again right after its grant");

// a stalled player read keeps its address and wins the next cycle
ply_req_held: assert property (@(posedge clk) disable iff (rst)
  ply_req && !ply_gnt |=> ply_gnt && $stable(ply_addr))
  else $error("player read stalled more than one cycle or changed its address");

// a write into the last free slot would make the full ring look empty
ring_no_lap: assert property (@(posedge clk) disable iff (rst)
  rec_gnt |-> (RAM_AW'(rec_addr + 1'b1) != ply_addr))
  else $error("recorder write pointer lapped the player read pointer");

endmodule: r5p_soc_props

bind r5p_bus_arbiter r5p_soc_props props (
  .clk      (clk),
  .rst      (rst),
  .rec_req  (rec_req),
  .rec_gnt  (rec_gnt),
  .ply_req  (ply_req),
  .ply_gnt  (ply_gnt),
  .rec_addr (rec_addr),
  .ply_addr (ply_addr)
);

//--- verification/r5p_soc_trace.txt
// value (hex), hold (cycles), random extra hold 0..3 (0/1), repeat count, expected overrun (0/1)
// a repeated line adds its repeat index to the value, holds below 4 form the overrun burst
0001 10 0 1 0
0002 4 0 1 0
00a5 7 1 1 0
5a5a 4 0 1 0
ffff 12 1 1 0
0000 5 0 1 0
8000 20 1 1 0
1234 9 0 1 0
4321 70000 0 1 0
0c0c 16 1 1 0
0100 6 1 40 0
0200 4 0 30 0
7e7e 5 1 1 0
0001 8 0 1 0
3c3c 4 1 1 0
c3c3 11 0 1 0
beef 200 0 1 0
0f0f 1 0 1 0
f0f0 1 0 1 1
0f0f 1 0 1 1
00ff 1 0 1 1
ff00 150 0 1 1
